/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;                  // Data and address width
    localparam int REG_ADDR_W = 5;                   // Register index width
    localparam int SHAMT_W    = $clog2(XLEN);        // Shift amount bits
    localparam int IMEM_WORDS = 64;                  // Instruction ROM depth
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);  // ROM word index width
    localparam int DMEM_BYTES = 256;                 // Data RAM size
    localparam int DMEM_AW    = $clog2(DMEM_BYTES);  // RAM byte index width
    localparam int OPCODE_W   = 7;

    // Major opcodes of the supported subset
    localparam logic [OPCODE_W-1:0] OPC_OP     = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OPC_LUI    = 7'b0110111;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8    // Used by LUI
    } alu_op_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [OPCODE_W-1:0]   opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm11_0;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [OPCODE_W-1:0]   opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]            imm11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm4_0;
        logic [OPCODE_W-1:0]   opcode;
    } s_type_t;

    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [OPCODE_W-1:0]   opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0]           imm31_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [OPCODE_W-1:0]   opcode;
    } u_type_t;

    typedef struct packed {
        logic                  imm20;
        logic [9:0]            imm10_1;
        logic                  imm11;
        logic [7:0]            imm19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [OPCODE_W-1:0]   opcode;
    } j_type_t;

    // One instruction word, viewed in every encoding format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_u;

endpackage

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [rv_pkg::XLEN-1:0] a_i,
    input  logic [rv_pkg::XLEN-1:0] b_i,
    input  rv_pkg::alu_op_e         op_i,
    output logic [rv_pkg::XLEN-1:0] result_o,
    output logic                    eq_o
);

    logic [rv_pkg::SHAMT_W-1:0] shamt;
    logic                       lt;

    assign shamt = b_i[rv_pkg::SHAMT_W-1:0];
    assign lt    = $signed(a_i) < $signed(b_i);  // SLT and SLTI

    always_comb begin
        case (op_i)
            rv_pkg::ALU_ADD:    result_o = a_i + b_i;
            rv_pkg::ALU_SUB:    result_o = a_i - b_i;
            rv_pkg::ALU_AND:    result_o = a_i & b_i;
            rv_pkg::ALU_OR:     result_o = a_i | b_i;
            rv_pkg::ALU_XOR:    result_o = a_i ^ b_i;
            rv_pkg::ALU_SLT:    result_o = {{(rv_pkg::XLEN-1){1'b0}}, lt};
            rv_pkg::ALU_SLL:    result_o = a_i << shamt;
            rv_pkg::ALU_SRL:    result_o = a_i >> shamt;
            rv_pkg::ALU_PASS_B: result_o = b_i;
            default:            result_o = '0;
        endcase
    end

    assign eq_o = (a_i == b_i);  // Branch compare of rs1 and rs2

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                          clk_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                          we_i,
    input  logic [rv_pkg::XLEN-1:0]       wd_i,
    output logic [rv_pkg::XLEN-1:0]       rd1_o,
    output logic [rv_pkg::XLEN-1:0]       rd2_o
);

    logic [rv_pkg::XLEN-1:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk_i) begin
        if (we_i && rd_i != '0) begin
            regs[rd_i] <= wd_i;
        end
    end

    assign rd1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rd2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

/* hdl/alu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_top (
    input  logic                          clk_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                          reg_write_i,
    input  logic                          result_src_i,
    input  logic                          alu_src_i,
    input  logic                          jump_store_i,
    input  logic [rv_pkg::XLEN-1:0]       imm_op_i,
    input  logic [rv_pkg::XLEN-1:0]       mem_read_val_i,
    input  rv_pkg::alu_op_e               alu_ctrl_i,
    input  logic [rv_pkg::XLEN-1:0]       pc_plus4_i,
    output logic                          eq_o,
    output logic [rv_pkg::XLEN-1:0]       alu_out_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_val_o
);

    logic [rv_pkg::XLEN-1:0] rs1_val;
    logic [rv_pkg::XLEN-1:0] alu_b;
    logic [rv_pkg::XLEN-1:0] wb_val;

    reg_file u_reg_file (
        .clk_i (clk_i),
        .rs1_i (rs1_i),
        .rs2_i (rs2_i),
        .rd_i  (rd_i),
        .we_i  (reg_write_i),
        .wd_i  (wb_val),
        .rd1_o (rs1_val),
        .rd2_o (rs2_val_o)
    );

    assign alu_b = alu_src_i ? imm_op_i : rs2_val_o;

    alu u_alu (
        .a_i      (rs1_val),
        .b_i      (alu_b),
        .op_i     (alu_ctrl_i),
        .result_o (alu_out_o),
        .eq_o     (eq_o)
    );

    // Link address wins for JAL and JALR
    assign wb_val = jump_store_i ? pc_plus4_i :
                    result_src_i ? mem_read_val_i : alu_out_o;

endmodule

`default_nettype wire

/* hdl/pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic [rv_pkg::XLEN-1:0] imm_op_i,
    input  logic                    pc_src_i,
    input  logic [rv_pkg::XLEN-1:0] jalr_target_i,
    input  logic                    jalr_pc_src_i,
    output logic [rv_pkg::XLEN-1:0] pc_o,
    output logic [rv_pkg::XLEN-1:0] pc_plus4_o
);

    logic [rv_pkg::XLEN-1:0] next_pc;

    assign pc_plus4_o = pc_o + 32'd4;

    always_comb begin
        if (jalr_pc_src_i) begin
            next_pc = {jalr_target_i[rv_pkg::XLEN-1:1], 1'b0};  // LSB cleared
        end else if (pc_src_i) begin
            next_pc = pc_o + imm_op_i;  // Taken branch or JAL
        end else begin
            next_pc = pc_plus4_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_o <= '0;
        end else begin
            pc_o <= next_pc;
        end
    end

endmodule

`default_nettype wire

/* hdl/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory (
    input  logic                    clk_i,
    input  logic [rv_pkg::XLEN-1:0] address_i,
    input  logic                    write_enable_i,
    input  logic [rv_pkg::XLEN-1:0] write_data_i,
    input  logic                    mem_type_i,     // 1 byte, 0 word
    input  logic                    mem_sign_i,     // 1 sign-extend byte load
    output logic [rv_pkg::XLEN-1:0] read_value_o
);

    logic [7:0]                 mem [rv_pkg::DMEM_BYTES];
    logic [rv_pkg::DMEM_AW-1:0] byte_addr [4];  // Little-endian byte lanes
    logic [rv_pkg::XLEN-1:0]    word_val;
    logic [7:0]                 byte_val;

    // Address wraps within the RAM size
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            byte_addr[k] = address_i[rv_pkg::DMEM_AW-1:0] + rv_pkg::DMEM_AW'(k);
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_enable_i) begin
            for (int k = 0; k < 4; k++) begin
                if (!mem_type_i || k == 0) begin  // SB touches lane 0 only
                    mem[byte_addr[k]] <= write_data_i[8*k +: 8];
                end
            end
        end
    end

    assign word_val = {mem[byte_addr[3]], mem[byte_addr[2]],
                       mem[byte_addr[1]], mem[byte_addr[0]]};
    assign byte_val = mem[byte_addr[0]];

    always_comb begin
        if (!mem_type_i) begin
            read_value_o = word_val;
        end else if (mem_sign_i) begin
            read_value_o = {{(rv_pkg::XLEN-8){byte_val[7]}}, byte_val};  // LB
        end else begin
            read_value_o = {{(rv_pkg::XLEN-8){1'b0}}, byte_val};  // LBU
        end
    end

endmodule

`default_nettype wire

/* hdl/control_top.sv */
`timescale 1ns/1ps
`default_nettype none

module control_top (
    input  logic [rv_pkg::XLEN-1:0]       pc_i,
    input  logic                          eq_i,
    output logic                          jump_store_o,   // Write pc+4 to rd
    output logic                          pc_src_o,       // Take pc+imm
    output logic                          result_src_o,   // Write back memory value
    output logic                          mem_write_o,
    output logic                          alu_src_o,      // Immediate as operand b
    output logic                          reg_write_o,
    output logic                          jalr_pc_src_o,  // Take ALU result as next PC
    output logic                          mem_type_o,     // 1 byte, 0 word
    output logic                          mem_sign_o,     // 1 sign-extend byte load
    output rv_pkg::alu_op_e               alu_ctrl_o,
    output logic [rv_pkg::XLEN-1:0]       imm_op_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rd_o
);

    logic [rv_pkg::XLEN-1:0] rom [rv_pkg::IMEM_WORDS];
    rv_pkg::instr_u          instr;
    rv_pkg::alu_op_e         f3_op;    // ALU op from funct3
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_s;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_j;

    initial begin
        $readmemh("program.hex", rom);
    end

    assign instr = rom[pc_i[rv_pkg::IMEM_AW+1:2]];  // Word index

    assign rs1_o = instr.r.rs1;
    assign rs2_o = instr.r.rs2;
    assign rd_o  = instr.r.rd;

    // Sign-extended immediates of each format
    assign imm_i = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0};
    assign imm_s = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
    assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign imm_u = {instr.u.imm31_12, 12'b0};
    assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    always_comb begin
        case (instr.r.funct3)
            3'b000: begin
                // funct7[5] means SUB only for register forms
                if (instr.r.opcode == rv_pkg::OPC_OP && instr.r.funct7[5]) begin
                    f3_op = rv_pkg::ALU_SUB;
                end else begin
                    f3_op = rv_pkg::ALU_ADD;
                end
            end
            3'b001:  f3_op = rv_pkg::ALU_SLL;
            3'b010:  f3_op = rv_pkg::ALU_SLT;
            3'b100:  f3_op = rv_pkg::ALU_XOR;
            3'b101:  f3_op = rv_pkg::ALU_SRL;
            3'b110:  f3_op = rv_pkg::ALU_OR;
            3'b111:  f3_op = rv_pkg::ALU_AND;
            default: f3_op = rv_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        jump_store_o  = 1'b0;
        pc_src_o      = 1'b0;
        result_src_o  = 1'b0;
        mem_write_o   = 1'b0;
        alu_src_o     = 1'b0;
        reg_write_o   = 1'b0;
        jalr_pc_src_o = 1'b0;
        mem_type_o    = 1'b0;
        mem_sign_o    = 1'b0;
        alu_ctrl_o    = rv_pkg::ALU_ADD;
        imm_op_o      = '0;
        case (instr.r.opcode)
            rv_pkg::OPC_OP: begin
                reg_write_o = 1'b1;
                alu_ctrl_o  = f3_op;
            end
            rv_pkg::OPC_OP_IMM: begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_ctrl_o  = f3_op;
                imm_op_o    = imm_i;
            end
            rv_pkg::OPC_LOAD: begin
                reg_write_o  = 1'b1;
                result_src_o = 1'b1;
                alu_src_o    = 1'b1;
                mem_type_o   = (instr.i.funct3 != 3'b010);  // LB or LBU
                mem_sign_o   = (instr.i.funct3 == 3'b000);  // LB
                imm_op_o     = imm_i;
            end
            rv_pkg::OPC_STORE: begin
                mem_write_o = 1'b1;
                alu_src_o   = 1'b1;
                mem_type_o  = (instr.s.funct3 == 3'b000);   // SB
                imm_op_o    = imm_s;
            end
            rv_pkg::OPC_BRANCH: begin
                // BNE when funct3[0] is set, BEQ otherwise
                pc_src_o = instr.b.funct3[0] ? !eq_i : eq_i;
                imm_op_o = imm_b;
            end
            rv_pkg::OPC_JAL: begin
                reg_write_o  = 1'b1;
                jump_store_o = 1'b1;
                pc_src_o     = 1'b1;
                imm_op_o     = imm_j;
            end
            rv_pkg::OPC_JALR: begin
                reg_write_o   = 1'b1;
                jump_store_o  = 1'b1;
                alu_src_o     = 1'b1;
                jalr_pc_src_o = 1'b1;  // Target is rs1 + imm
                imm_op_o      = imm_i;
            end
            rv_pkg::OPC_LUI: begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_ctrl_o  = rv_pkg::ALU_PASS_B;
                imm_op_o    = imm_u;
            end
            default: ;  // Unsupported opcode acts as a NOP
        endcase
    end

endmodule

`default_nettype wire

/* hdl/top.sv */
`timescale 1ns/1ps
`default_nettype none

module top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    output logic [rv_pkg::XLEN-1:0]  pc_o,
    output logic                     dmem_we_o,
    output logic [rv_pkg::XLEN-1:0]  dmem_addr_o,
    output logic [rv_pkg::XLEN-1:0]  dmem_wdata_o
);

    logic [rv_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_pkg::XLEN-1:0]       pc;
    logic [rv_pkg::XLEN-1:0]       pc_plus4;
    logic [rv_pkg::XLEN-1:0]       imm_op;
    logic [rv_pkg::XLEN-1:0]       alu_out;      // Also the memory address and JALR target
    logic [rv_pkg::XLEN-1:0]       rs2_val;      // Store data
    logic [rv_pkg::XLEN-1:0]       read_value;
    logic                          eq;
    logic                          pc_src;
    logic                          jalr_pc_src;
    logic                          jump_store;
    logic                          result_src;
    logic                          mem_write;
    logic                          mem_type;
    logic                          mem_sign;
    logic                          alu_src;
    logic                          reg_write;
    rv_pkg::alu_op_e               alu_ctrl;

    control_top u_control (
        .pc_i          (pc),
        .eq_i          (eq),
        .jump_store_o  (jump_store),
        .pc_src_o      (pc_src),
        .result_src_o  (result_src),
        .mem_write_o   (mem_write),
        .alu_src_o     (alu_src),
        .reg_write_o   (reg_write),
        .jalr_pc_src_o (jalr_pc_src),
        .mem_type_o    (mem_type),
        .mem_sign_o    (mem_sign),
        .alu_ctrl_o    (alu_ctrl),
        .imm_op_o      (imm_op),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rd_o          (rd)
    );

    alu_top u_alu_top (
        .clk_i          (clk_i),
        .rs1_i          (rs1),
        .rs2_i          (rs2),
        .rd_i           (rd),
        .reg_write_i    (reg_write),
        .result_src_i   (result_src),
        .alu_src_i      (alu_src),
        .jump_store_i   (jump_store),
        .imm_op_i       (imm_op),
        .mem_read_val_i (read_value),
        .alu_ctrl_i     (alu_ctrl),
        .pc_plus4_i     (pc_plus4),
        .eq_o           (eq),
        .alu_out_o      (alu_out),
        .rs2_val_o      (rs2_val)
    );

    pc_unit u_pc_unit (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .imm_op_i      (imm_op),
        .pc_src_i      (pc_src),
        .jalr_target_i (alu_out),
        .jalr_pc_src_i (jalr_pc_src),
        .pc_o          (pc),
        .pc_plus4_o    (pc_plus4)
    );

    data_memory u_data_memory (
        .clk_i          (clk_i),
        .address_i      (alu_out),
        .write_enable_i (mem_write),
        .write_data_i   (rs2_val),
        .mem_type_i     (mem_type),
        .mem_sign_i     (mem_sign),
        .read_value_o   (read_value)
    );

    // Observation of fetch and store traffic
    assign pc_o         = pc;
    assign dmem_we_o    = mem_write;
    assign dmem_addr_o  = alu_out;
    assign dmem_wdata_o = rs2_val;

endmodule

`default_nettype wire

/* testbench/top_props.sv */
`timescale 1ns/1ps
`default_nettype none

module top_props (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic [rv_pkg::XLEN-1:0] pc_i,
    input  logic                    dmem_we_i,
    input  logic [rv_pkg::XLEN-1:0] dmem_addr_i,
    input  logic [rv_pkg::XLEN-1:0] dmem_wdata_i
);

    localparam logic [3:0] NUM_STORES = 4'd15;
    localparam int         NUM_JUMPS  = 5;

    // Stores of program.hex in program order
    localparam logic [rv_pkg::XLEN-1:0] STORE_ADDR [NUM_STORES] = '{
        32'h00, 32'h04, 32'h08, 32'h0C, 32'h10, 32'h14, 32'h18, 32'h1C,
        32'h20, 32'h24, 32'h25, 32'h28, 32'h2C, 32'h30, 32'h34
    };
    localparam logic [rv_pkg::XLEN-1:0] STORE_DATA [NUM_STORES] = '{
        32'h0000_0007, 32'h0000_0011, 32'hFFFF_FFF7, 32'h0000_0018,
        32'h7FFF_FFFD, 32'hFFFF_FF0C, 32'h0000_001F, 32'h0000_007C,
        32'h0000_008C, 32'h1234_5680, 32'h1234_5680, 32'hFFFF_FF80,
        32'h0000_0080, 32'h1234_8080, 32'h0000_0000
    };

    // Taken branches, JAL, JALR and the final self-loop
    localparam logic [rv_pkg::XLEN-1:0] JUMP_FROM [NUM_JUMPS] = '{
        32'h64, 32'h6C, 32'h78, 32'h88, 32'hC8
    };
    localparam logic [rv_pkg::XLEN-1:0] JUMP_TO [NUM_JUMPS] = '{
        32'h6C, 32'h74, 32'h80, 32'h94, 32'hC8
    };

    logic [3:0]              store_idx;
    logic [rv_pkg::XLEN-1:0] exp_addr;
    logic [rv_pkg::XLEN-1:0] exp_data;
    logic [rv_pkg::XLEN-1:0] prev_pc;
    logic                    prev_run = 1'b0;
    int unsigned             fail_cnt = 0;   // Polled by tb_top

    // A listed source PC must reach its target, any other steps by 4
    function automatic logic step_ok(input logic [rv_pkg::XLEN-1:0] from_pc,
                                     input logic [rv_pkg::XLEN-1:0] to_pc);
        logic ok;
        ok = (to_pc == from_pc + 32'd4);
        for (int k = 0; k < NUM_JUMPS; k++) begin
            if (JUMP_FROM[k] == from_pc) begin
                ok = (JUMP_TO[k] == to_pc);
            end
        end
        return ok;
    endfunction

    always_ff @(posedge clk_i) begin
        prev_pc  <= pc_i;
        prev_run <= rst_n_i;
        if (!rst_n_i) begin
            store_idx <= '0;
        end else if (dmem_we_i && store_idx != NUM_STORES) begin
            store_idx <= store_idx + 4'd1;
        end
    end

    always_comb begin
        exp_addr = '0;
        exp_data = '0;
        if (store_idx < NUM_STORES) begin
            exp_addr = STORE_ADDR[store_idx];
            exp_data = STORE_DATA[store_idx];
        end
    end

    pc_reset_zero: assert property (@(posedge clk_i) !rst_n_i |=> pc_i == '0)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ERROR pc_o 0x%08h after a reset cycle, expected 0x00000000", pc_i);
        end

    pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pc_i[1:0] == 2'b00)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ERROR pc_o 0x%08h is not word aligned", pc_i);
        end

    pc_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_run |-> step_ok(prev_pc, pc_i))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ERROR pc_o 0x%08h -> 0x%08h is not a legal step", prev_pc, pc_i);
        end

    store_count: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dmem_we_i |-> store_idx < NUM_STORES)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("store to 0x%08h came after all expected stores", dmem_addr_i);
        end

    store_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (dmem_we_i && store_idx < NUM_STORES) |-> dmem_addr_i == exp_addr)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ERROR dmem_addr_o 0x%08h, expected 0x%08h", dmem_addr_i, exp_addr);
        end

    store_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (dmem_we_i && store_idx < NUM_STORES) |-> dmem_wdata_i == exp_data)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ERROR dmem_wdata_o 0x%08h, expected 0x%08h", dmem_wdata_i, exp_data);
        end

endmodule

`default_nettype wire

/* testbench/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int                      MAX_CYCLES = 200;   // Program needs about 55
    localparam int                      LOOP_HOLD  = 5;
    localparam int                      NUM_STORES = 15;
    localparam logic [rv_pkg::XLEN-1:0] LOOP_PC    = 32'h0000_00C8;  // jal x0, 0

    logic                    clk_i;
    logic                    rst_n_i;
    logic [rv_pkg::XLEN-1:0] pc_o;
    logic                    dmem_we_o;
    logic [rv_pkg::XLEN-1:0] dmem_addr_o;
    logic [rv_pkg::XLEN-1:0] dmem_wdata_o;
    int                      cycle_cnt   = 0;
    int                      loop_cnt    = 0;   // Cycles spent at LOOP_PC
    int                      stores_seen = 0;

    top dut0 (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .pc_o         (pc_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o)
    );

    bind top top_props u_props (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .pc_i         (pc_o),
        .dmem_we_i    (dmem_we_o),
        .dmem_addr_i  (dmem_addr_o),
        .dmem_wdata_i (dmem_wdata_o)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    initial begin
        clk_i = 1'b0;
    end

    always #2 clk_i = ~clk_i;   // 4 ns period

    initial begin
        rst_n_i <= 1'b0;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
    end

    // Run state and end of test at each falling edge
    always @(negedge clk_i) begin
        if (dut0.u_props.fail_cnt != 0) begin
            stop_with_failure("a bound property on the DUT failed");
        end else if (cycle_cnt >= MAX_CYCLES) begin
            stop_with_failure("timeout, the PC never settled in the final self-loop");
        end else if (loop_cnt >= LOOP_HOLD) begin
            if (stores_seen == NUM_STORES) begin
                $display("Test passed");
                $finish;
            end else begin
                stop_with_failure($sformatf("only %0d of %0d expected stores were seen",
                                            stores_seen, NUM_STORES));
            end
        end else begin
            cycle_cnt = cycle_cnt + 1;
            if (rst_n_i) begin
                if (dmem_we_o) begin
                    stores_seen = stores_seen + 1;
                end
                if (pc_o == LOOP_PC) begin
                    loop_cnt = loop_cnt + 1;
                end else begin
                    loop_cnt = 0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* program.hex */
// One instruction word per line in hex, word address 0 first
00C00093  // 00 addi x1, x0, 12
FFB00113  // 04 addi x2, x0, -5
002081B3  // 08 add  x3, x1, x2
00302023  // 0C sw   x3, 0(x0)
40208233  // 10 sub  x4, x1, x2
00402223  // 14 sw   x4, 4(x0)
0020F2B3  // 18 and  x5, x1, x2
0020E333  // 1C or   x6, x1, x2
0062C3B3  // 20 xor  x7, x5, x6
00702423  // 24 sw   x7, 8(x0)
00112433  // 28 slt  x8, x2, x1
008094B3  // 2C sll  x9, x1, x8
00815533  // 30 srl  x10, x2, x8
00902623  // 34 sw   x9, 12(x0)
00A02823  // 38 sw   x10, 16(x0)
0F017593  // 3C andi x11, x2, 0xF0
0035E593  // 40 ori  x11, x11, 3
FFF5C593  // 44 xori x11, x11, -1
0005A613  // 48 slti x12, x11, 0
00461693  // 4C slli x13, x12, 4
01C5D713  // 50 srli x14, x11, 28
00E687B3  // 54 add  x15, x13, x14
00B02A23  // 58 sw   x11, 20(x0)
00F02C23  // 5C sw   x15, 24(x0)
00208463  // 60 beq  x1, x2, +8 not taken
00209463  // 64 bne  x1, x2, +8 taken
00102E23  // 68 sw   x1, 28(x0) skipped
00108463  // 6C beq  x1, x1, +8 taken
00202E23  // 70 sw   x2, 28(x0) skipped
00109463  // 74 bne  x1, x1, +8 not taken
0080086F  // 78 jal  x16, +8
00102E23  // 7C sw   x1, 28(x0) skipped
01002E23  // 80 sw   x16, 28(x0)
08F00893  // 84 addi x17, x0, 0x8F
00688967  // 88 jalr x18, 6(x17) lands at 0x94
02102023  // 8C sw   x1, 32(x0) skipped
02102023  // 90 sw   x1, 32(x0) skipped
03202023  // 94 sw   x18, 32(x0)
123459B7  // 98 lui  x19, 0x12345
68098993  // 9C addi x19, x19, 0x680
03302223  // A0 sw   x19, 36(x0)
033002A3  // A4 sb   x19, 37(x0)
02500A03  // A8 lb   x20, 37(x0)
02504A83  // AC lbu  x21, 37(x0)
02402B03  // B0 lw   x22, 36(x0)
03402423  // B4 sw   x20, 40(x0)
03502623  // B8 sw   x21, 44(x0)
03602823  // BC sw   x22, 48(x0)
00508013  // C0 addi x0, x1, 5
02002A23  // C4 sw   x0, 52(x0)
0000006F  // C8 jal  x0, 0

/* tb.f */
hdl/rv_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/alu_top.sv
hdl/pc_unit.sv
hdl/data_memory.sv
hdl/control_top.sv
hdl/top.sv
testbench/top_props.sv
testbench/tb_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim &&
./obj_dir/tb_sim +verilator+error+limit+100 ||
exit 1
